/* Makefile */
# Verilator build and run of the RPN calculator testbench

VERILATOR ?= verilator
TOP       ?= calcTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/calcTb.sv */
/*
 * Directed testbench for the RPN calculator top level.
 * Each test task runs whole sessions and checks result and status after done.
 * Run through the file list with calcTb as the top module.
 */
module calcTb
    import calcKeyPkg::*, calcStatusPkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int finishTimeout = 50; // cycles from done to finished

    logic        ck = 1'b0;
    logic        rst_l;
    calcKey      key;
    calcWord     result;
    calcStatus   status;
    logic [31:0] lcgState = 32'd96549;
    int          errCount = 0;
    int          checkCount = 0;
    int          testsRun = 0;

    rpnCalc dut0 (
        .ck     (ck),
        .rst_l  (rst_l),
        .key    (key),
        .result (result),
        .status (status)
    );

    always #2 ck = ~ck; // 4 ns period

    ////////////////////
    // helpers
    ////////////////////

    function automatic calcWord nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15]; // upper bits since low ones cycle too fast
    endfunction

    // status at done; correct only when nothing else is flagged
    function automatic calcStatus expectedStatus(input logic stkOvf, input logic unexp,
                                                 input logic proto, input logic dataOvf);
        calcStatus s;
        s.finished       = 1'b1;
        s.stackOverflow  = stkOvf;
        s.unexpectedDone = unexp;
        s.protocolError  = proto;
        s.dataOverflow   = dataOvf;
        s.correct        = !(stkOvf || unexp || proto || dataOvf);
        return s;
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     testName, what, expected, actual);
            errCount++;
        end
    endtask

    task automatic pressKey(input logic [3:0] cmd, input calcWord payload);
        @(posedge ck);
        key.cmd     <= keyCmd'(cmd);
        key.payload <= payload;
    endtask

    task automatic releaseKey();
        @(posedge ck);
        key <= '0;
    endtask

    task automatic waitFinished(input string testName);
        int cycles;
        cycles = 0;
        do begin
            @(negedge ck); // outputs settled here
            cycles++;
        end while (!status.finished && cycles < finishTimeout);
        if (!status.finished) begin
            $display("ERROR %s: finished did not rise within %0d cycles after done",
                     testName, finishTimeout);
            errCount++;
        end
    endtask

    task automatic finishSession(input string testName);
        pressKey(cmdDone, '0);
        releaseKey();
        waitFinished(testName);
    endtask

    task automatic reportTest(input string testName, input int errBefore);
        testsRun++;
        if (errCount == errBefore) begin
            $display("test %s ok", testName);
        end else begin
            $display("test %s %0d errors", testName, errCount - errBefore);
        end
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic binaryOpsTest();
        string   name;
        int      errBefore;
        calcWord a, b, expRes;
        arithOp  op;
        int      sa, sb, wide;
        logic    expOvf;
        name = "binaryOps";
        errBefore = errCount;
        for (int i = 0; i < 24; i++) begin
            a  = nextRand();
            b  = nextRand();
            sa = $signed(a);
            sb = $signed(b);
            case (i % 3)
                0: begin
                    op = opAdd;
                    expRes = a + b;
                    wide = sa + sb;
                end
                1: begin
                    op = opSub;
                    expRes = a - b; // second minus top
                    wide = sa - sb;
                end
                default: begin
                    op = opAnd;
                    expRes = a & b;
                    wide = 0;
                end
            endcase
            expOvf = (wide > 32767) || (wide < -32768); // outside 16-bit signed
            pressKey(cmdStart, a);
            pressKey(cmdEnter, b);
            pressKey(cmdArith, op);
            finishSession(name);
            checkValue(name, "result", 32'(expRes), 32'(result));
            checkValue(name, "status", 32'(expectedStatus(1'b0, 1'b0, 1'b0, expOvf)),
                       32'(status));
        end
        reportTest(name, errBefore);
    endtask

    task automatic stackOpsTest();
        string   name;
        int      errBefore;
        calcWord x;
        name = "stackOps";
        errBefore = errCount;
        // swap then sub gives 5 - 1
        pressKey(cmdStart, 16'd1);
        pressKey(cmdEnter, 16'd5);
        pressKey(cmdArith, opSwap);
        pressKey(cmdArith, opSub);
        finishSession(name);
        checkValue(name, "swap result", 32'd4, 32'(result));
        checkValue(name, "swap status", 32'(expectedStatus(1'b0, 1'b0, 1'b0, 1'b0)),
                   32'(status));

        x = nextRand();
        pressKey(cmdStart, x);
        pressKey(cmdArith, opNegate);
        finishSession(name);
        checkValue(name, "negate result", 32'(16'(16'd0 - x)), 32'(result));
        checkValue(name, "negate status", 32'(expectedStatus(1'b0, 1'b0, 1'b0, 1'b0)),
                   32'(status));

        pressKey(cmdStart, 16'd3);
        pressKey(cmdEnter, 16'd7);
        pressKey(cmdArith, opPop);
        finishSession(name);
        checkValue(name, "pop result", 32'd3, 32'(result));
        checkValue(name, "pop status", 32'(expectedStatus(1'b0, 1'b0, 1'b0, 1'b0)),
                   32'(status));
        reportTest(name, errBefore);
    endtask

    task automatic overflowTest();
        string name;
        int    errBefore;
        name = "stackOvf";
        errBefore = errCount;
        pressKey(cmdStart, 16'd100);
        for (int i = 0; i < 8; i++) begin
            pressKey(cmdEnter, 16'(i)); // last one does not fit
        end
        finishSession(name);
        checkValue(name, "status", 32'(expectedStatus(1'b1, 1'b0, 1'b0, 1'b0)),
                   32'(status));
        reportTest(name, errBefore);
    endtask

    task automatic protocolErrorTest();
        string     name;
        int        errBefore;
        calcStatus exp;
        name = "protocolErr";
        errBefore = errCount;
        exp = expectedStatus(1'b0, 1'b0, 1'b1, 1'b0);

        pressKey(cmdStart, 16'd1);
        pressKey(cmdStart, 16'd2);
        finishSession(name);
        checkValue(name, "restart", 32'(exp), 32'(status));

        pressKey(cmdStart, 16'd1);
        pressKey(4'd7, 16'd0); // not a command
        finishSession(name);
        checkValue(name, "bad command", 32'(exp), 32'(status));

        pressKey(cmdStart, 16'd1);
        pressKey(cmdArith, 16'h15);
        finishSession(name);
        checkValue(name, "bad opcode", 32'(exp), 32'(status));

        pressKey(cmdStart, 16'd1);
        pressKey(cmdArith, opAdd);
        finishSession(name);
        checkValue(name, "underflow", 32'(exp), 32'(status));

        pressKey(cmdStart, 16'd1);
        pressKey(cmdArith, opPop);
        finishSession(name);
        checkValue(name, "emptied", 32'(exp), 32'(status));
        reportTest(name, errBefore);
    endtask

    task automatic unexpectedDoneTest();
        string name;
        int    errBefore;
        name = "unexpDone";
        errBefore = errCount;
        pressKey(cmdStart, 16'd11);
        pressKey(cmdEnter, 16'd22);
        finishSession(name);
        checkValue(name, "status", 32'(expectedStatus(1'b0, 1'b1, 1'b0, 1'b0)),
                   32'(status));
        reportTest(name, errBefore);
    endtask

    task automatic ignoredKeysTest();
        string     name;
        int        errBefore;
        calcStatus expStatus;
        name = "ignoredKeys";
        errBefore = errCount;
        expStatus = expectedStatus(1'b0, 1'b0, 1'b0, 1'b0);
        pressKey(cmdStart, 16'h1234);
        finishSession(name);
        checkValue(name, "result", 32'h1234, 32'(result));
        checkValue(name, "status", 32'(expStatus), 32'(status));

        // no start, so none of these may reach the stack
        pressKey(cmdEnter, 16'd5);
        pressKey(cmdEnter, 16'd6);
        pressKey(cmdArith, opAdd);
        pressKey(cmdDone, '0);
        releaseKey();
        for (int i = 0; i < 20; i++) begin
            @(negedge ck);
            checkValue(name, "held result", 32'h1234, 32'(result));
            checkValue(name, "held status", 32'(expStatus), 32'(status));
        end
        reportTest(name, errBefore);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        rst_l = 1'b0;
        key   = '0;
        repeat (10) @(posedge ck);
        rst_l <= 1'b1;
        @(negedge ck);
        checkValue("reset", "result", 32'd0, 32'(result));
        checkValue("reset", "status", 32'd0, 32'(status));

        binaryOpsTest();
        stackOpsTest();
        overflowTest();
        protocolErrorTest();
        unexpectedDoneTest();
        ignoredKeysTest();

        $display("tests %0d, checks %0d, errors %0d", testsRun, checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/calcKeyPkg.sv
logic/calcStatusPkg.sv
logic/sessionTracker.sv
logic/operandStack.sv
logic/resultReporter.sv
logic/rpnCalc.sv
dv/calcTb.sv

/* logic/calcKeyPkg.sv */
/*
 * Input protocol of the RPN calculator: commands, opcodes and key formats.
 * Imported by every unit that decodes keys, and by the testbench.
 */
package calcKeyPkg;

    ////////////////////
    // data path
    ////////////////////

    localparam int wordWidth = 16;

    typedef logic [wordWidth-1:0] calcWord;

    ////////////////////
    // command and opcode encodings
    ////////////////////

    // one-hot commands with zero for no key this cycle
    typedef enum logic [3:0] {
        cmdNone  = 4'h0,
        cmdStart = 4'h1,
        cmdEnter = 4'h2,
        cmdArith = 4'h4,
        cmdDone  = 4'h8
    } keyCmd;

    // one-hot opcodes carried in the payload of an arith key
    typedef enum logic [wordWidth-1:0] {
        opAdd    = 'h01,
        opSub    = 'h02, // second minus top
        opAnd    = 'h04,
        opSwap   = 'h08,
        opNegate = 'h10,
        opPop    = 'h20
    } arithOp;

    typedef struct packed {
        keyCmd   cmd;
        calcWord payload; // operand or opcode
    } calcKey;

    // key after session filtering
    typedef struct packed {
        logic   valid;
        calcKey key;
    } acceptedKey;

endpackage

/* logic/calcStatusPkg.sv */
/*
 * Event strobes passed between the calculator units and the visible status.
 * All event fields are single-cycle and belong to the key of that cycle.
 */
package calcStatusPkg;

    ////////////////////
    // per-key events
    ////////////////////

    // from the operand stack
    typedef struct packed {
        logic overflow;     // push at full depth is dropped
        logic underflow;    // too few operands
        logic emptied;      // pop left nothing behind
        logic dataOverflow; // signed add/sub overflow
        logic badOpcode;
    } stackEvents;

    // from the session tracker
    typedef struct packed {
        logic start;    // session opened
        logic finish;   // session closed by done
        logic protoErr; // bad command inside a session
    } sessionEvents;

    ////////////////////
    // outputs
    ////////////////////

    typedef struct packed {
        logic finished;
        logic correct;
        logic stackOverflow;
        logic unexpectedDone;
        logic protocolError;
        logic dataOverflow;
    } calcStatus;

endpackage

/* logic/operandStack.sv */
/*
 * Operand stack with its arithmetic unit. Acts on each accepted key at the
 * next clock edge and reports stack and arithmetic events for that key.
 * The top of the stack lives at index depth-1.
 */
module operandStack
    import calcKeyPkg::*, calcStatusPkg::*;
#(
    parameter  int stackDepth = 8,
    localparam int depthW     = $clog2(stackDepth + 1)
) (
    input  logic              ck,
    input  logic              rst_l,
    input  acceptedKey        accKey,
    output calcWord           top,
    output logic [depthW-1:0] depth,
    output stackEvents        events
);

    localparam int idxW = $clog2(stackDepth);
    localparam int msb  = wordWidth - 1;
    localparam logic [depthW-1:0] fullDepth = depthW'(stackDepth);

    // one write port of the register array
    typedef struct packed {
        logic            en;
        logic [idxW-1:0] idx;
        calcWord         data;
    } wrPort;

    calcWord           mem [stackDepth];
    logic [depthW-1:0] depthQ, depthNext;
    logic [idxW-1:0]   topIdx, secIdx, pushIdx;
    calcWord           topW, secW;
    calcWord           sum, diff, aluOut;
    logic              aluOvf;
    wrPort             wrA, wrB;
    arithOp            op;
    logic              isStart, isEnter, isArith;
    logic              hasOne, hasTwo;

    ////////////////////
    // operand fetch
    ////////////////////

    assign topIdx  = idxW'(depthQ - 1'b1);
    assign secIdx  = idxW'(depthQ - 2'd2);
    assign pushIdx = idxW'(depthQ); // only used below full depth
    assign topW    = mem[topIdx];
    assign secW    = mem[secIdx];

    assign hasOne = depthQ != '0;
    assign hasTwo = depthQ > depthW'(1);

    assign op      = arithOp'(accKey.key.payload);
    assign isStart = accKey.valid && (accKey.key.cmd == cmdStart);
    assign isEnter = accKey.valid && (accKey.key.cmd == cmdEnter);
    assign isArith = accKey.valid && (accKey.key.cmd == cmdArith);

    assign top   = hasOne ? topW : '0;
    assign depth = depthQ;

    ////////////////////
    // arithmetic unit
    ////////////////////

    assign sum  = secW + topW;
    assign diff = secW - topW;

    always_comb begin
        aluOut = secW & topW;
        aluOvf = 1'b0;
        if (op == opAdd) begin
            aluOut = sum;
            // same operand signs with the result sign flipped
            aluOvf = (secW[msb] == topW[msb]) && (sum[msb] != secW[msb]);
        end else if (op == opSub) begin
            aluOut = diff;
            aluOvf = (secW[msb] != topW[msb]) && (diff[msb] != secW[msb]);
        end
    end

    ////////////////////
    // key execution
    ////////////////////

    always_comb begin
        depthNext = depthQ;
        wrA       = '0;
        wrB       = '0;
        events    = '0;

        if (isStart) begin
            // fresh session discards old contents
            depthNext = depthW'(1);
            wrA.en    = 1'b1;
            wrA.idx   = '0;
            wrA.data  = accKey.key.payload;
        end else if (isEnter) begin
            if (depthQ == fullDepth) begin
                events.overflow = 1'b1; // value is lost
            end else begin
                depthNext = depthQ + 1'b1;
                wrA.en    = 1'b1;
                wrA.idx   = pushIdx;
                wrA.data  = accKey.key.payload;
            end
        end else if (isArith) begin
            case (op)
                opAdd, opSub, opAnd: begin
                    if (!hasTwo) begin
                        events.underflow = 1'b1;
                    end else begin
                        depthNext           = depthQ - 1'b1;
                        wrA.en              = 1'b1;
                        wrA.idx             = secIdx; // result replaces both
                        wrA.data            = aluOut;
                        events.dataOverflow = aluOvf;
                    end
                end
                opSwap: begin
                    if (!hasTwo) begin
                        events.underflow = 1'b1;
                    end else begin
                        wrA.en   = 1'b1;
                        wrA.idx  = topIdx;
                        wrA.data = secW;
                        wrB.en   = 1'b1;
                        wrB.idx  = secIdx;
                        wrB.data = topW;
                    end
                end
                opNegate: begin
                    if (!hasOne) begin
                        events.underflow = 1'b1;
                    end else begin
                        wrA.en   = 1'b1;
                        wrA.idx  = topIdx;
                        wrA.data = ~topW + 1'b1; // two's complement
                    end
                end
                opPop: begin
                    if (!hasOne) begin
                        events.underflow = 1'b1;
                    end else begin
                        depthNext      = depthQ - 1'b1;
                        events.emptied = depthQ == depthW'(1);
                    end
                end
                default: begin
                    events.badOpcode = 1'b1;
                end
            endcase
        end
    end

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge ck) begin
        if (wrA.en) begin
            mem[wrA.idx] <= wrA.data;
        end
        if (wrB.en) begin
            mem[wrB.idx] <= wrB.data; // second port used by swap only
        end
    end

    always_ff @(posedge ck or negedge rst_l) begin
        if (!rst_l) begin
            depthQ <= '0;
        end else begin
            depthQ <= depthNext;
        end
    end

endmodule

/* logic/resultReporter.sv */
/*
 * Collects the error events of a session and publishes result and status
 * at done. Outputs hold until the next session is opened.
 */
module resultReporter
    import calcKeyPkg::*, calcStatusPkg::*;
#(
    parameter  int stackDepth = 8,
    localparam int depthW     = $clog2(stackDepth + 1)
) (
    input  logic              ck,
    input  logic              rst_l,
    input  sessionEvents      sessEvents,
    input  stackEvents        stkEvents,
    input  calcWord           top,
    input  logic [depthW-1:0] depth,
    output calcWord           result,
    output calcStatus         status
);

    typedef struct packed {
        logic stackOverflow;
        logic protocolError;
        logic dataOverflow;
    } errFlags;

    errFlags   sticky, curErr;
    calcStatus doneStatus;
    logic      anyErr;

    // sticky flags merged with this cycle's events
    always_comb begin
        curErr.stackOverflow = sticky.stackOverflow | stkEvents.overflow;
        curErr.protocolError = sticky.protocolError | sessEvents.protoErr |
                               stkEvents.underflow | stkEvents.emptied |
                               stkEvents.badOpcode;
        curErr.dataOverflow  = sticky.dataOverflow | stkEvents.dataOverflow;
    end

    ////////////////////
    // done-time rules
    ////////////////////

    always_comb begin
        doneStatus.finished       = 1'b1;
        doneStatus.stackOverflow  = curErr.stackOverflow;
        doneStatus.protocolError  = curErr.protocolError || (depth == '0);
        doneStatus.dataOverflow   = curErr.dataOverflow;
        anyErr = doneStatus.stackOverflow | doneStatus.protocolError |
                 doneStatus.dataOverflow;
        // leftovers on the stack count only when nothing else went wrong
        doneStatus.unexpectedDone = !anyErr && (depth > depthW'(1));
        doneStatus.correct        = !anyErr && (depth == depthW'(1));
    end

    always_ff @(posedge ck or negedge rst_l) begin
        if (!rst_l) begin
            sticky <= '0;
            result <= '0;
            status <= '0;
        end else if (sessEvents.start) begin
            sticky <= '0; // new session
            result <= '0;
            status <= '0;
        end else begin
            sticky <= curErr;
            if (sessEvents.finish) begin
                result <= top;
                status <= doneStatus;
            end
        end
    end

endmodule

/* logic/rpnCalc.sv */
/*
 * Top of the 16-bit RPN calculator. One key per cycle goes in; result and
 * status appear one cycle after done. stackDepth sets the operand stack size.
 */
module rpnCalc
    import calcKeyPkg::*, calcStatusPkg::*;
#(
    parameter int stackDepth = 8
) (
    input  logic      ck,
    input  logic      rst_l,
    input  calcKey    key,
    output calcWord   result,
    output calcStatus status
);

    localparam int depthW = $clog2(stackDepth + 1);

    acceptedKey        accKey;
    sessionEvents      sessEv;
    stackEvents        stkEv;
    calcWord           stkTop;
    logic [depthW-1:0] stkDepth;

    // tracker and stack see the same key in the same cycle
    sessionTracker tracker0 (
        .ck     (ck),
        .rst_l  (rst_l),
        .key    (key),
        .accKey (accKey),
        .events (sessEv)
    );

    operandStack #(.stackDepth(stackDepth)) stack0 (
        .ck     (ck),
        .rst_l  (rst_l),
        .accKey (accKey),
        .top    (stkTop),
        .depth  (stkDepth),
        .events (stkEv)
    );

    resultReporter #(.stackDepth(stackDepth)) reporter0 (
        .ck         (ck),
        .rst_l      (rst_l),
        .sessEvents (sessEv),
        .stkEvents  (stkEv),
        .top        (stkTop),
        .depth      (stkDepth),
        .result     (result),
        .status     (status)
    );

endmodule

/* logic/sessionTracker.sv */
/*
 * Session FSM of the calculator. Decides which keys reach the stack and
 * raises the session strobes. Keys outside a session, other than start,
 * are dropped silently.
 */
module sessionTracker
    import calcKeyPkg::*, calcStatusPkg::*;
(
    input  logic         ck,
    input  logic         rst_l,
    input  calcKey       key,
    output acceptedKey   accKey,
    output sessionEvents events
);

    typedef enum logic {
        stIdle,
        stActive
    } sessState;

    sessState state, stateNext;

    ////////////////////
    // key decode
    ////////////////////

    always_comb begin
        stateNext    = state;
        accKey.valid = 1'b0;
        accKey.key   = key; // payload passes untouched
        events       = '0;

        case (state)
            stIdle: begin
                // only a start opens a session
                if (key.cmd == cmdStart) begin
                    accKey.valid = 1'b1;
                    events.start = 1'b1;
                    stateNext    = stActive;
                end
            end

            stActive: begin
                case (key.cmd)
                    cmdNone: ; // no key this cycle
                    cmdStart: begin
                        // restart inside a session is flagged and not forwarded
                        events.protoErr = 1'b1;
                    end
                    cmdEnter, cmdArith: begin
                        accKey.valid = 1'b1;
                    end
                    cmdDone: begin
                        accKey.valid  = 1'b1;
                        events.finish = 1'b1;
                        stateNext     = stIdle;
                    end
                    default: begin
                        events.protoErr = 1'b1; // unknown command
                    end
                endcase
            end

            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    ////////////////////
    // state register
    ////////////////////

    always_ff @(posedge ck or negedge rst_l) begin
        if (!rst_l) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

endmodule
